//--- ram_pkg.sv
package ram_pkg;

    // ====================
    // Sizes
    // ====================

    localparam int NUM_BANKS  = 4;   // One bank per byte of the data word
    localparam int MAX_ADDR_W = 16;  // Widest byte address the request can carry

    // ====================
    // Data word
    // ====================

    typedef union packed {
        logic [31:0]                word;   // Whole word as seen on the AXI side
        logic [NUM_BANKS-1:0][7:0]  bytes;  // Byte lanes, lane 0 is the least significant
    } mem_word_u;

    typedef enum logic [1:0] {
        WIDTH_BYTE = 2'd0,
        WIDTH_HALF = 2'd1,
        WIDTH_WORD = 2'd2
    } access_width_e;

    // ====================
    // Requests and bank commands
    // ====================

    typedef struct packed {
        logic                    valid;
        logic                    write;
        logic [MAX_ADDR_W-1:0]   addr;   // Byte address, upper bits zero for smaller memories
        access_width_e           width;
        mem_word_u               wdata;  // Store data sits in the low lanes
    } mem_req_s;

    typedef struct packed {
        logic                    we;
        logic                    re;
        logic [MAX_ADDR_W-3:0]   row;    // Word row inside the bank
        logic [7:0]              data;
    } bank_cmd_s;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- axil_front.sv
module axil_front #(
    parameter int ADDR_W = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 awvalid,
    output logic                 awready,
    input  logic [ADDR_W-1:0]    awaddr,
    input  logic                 wvalid,
    output logic                 wready,
    input  logic [31:0]          wdata,
    input  logic [3:0]           wstrb,
    output logic                 bvalid,
    input  logic                 bready,
    output logic [1:0]           bresp,
    input  logic                 arvalid,
    output logic                 arready,
    input  logic [ADDR_W-1:0]    araddr,
    output logic                 rvalid,
    input  logic                 rready,
    output logic [31:0]          rdata,
    output logic [1:0]           rresp,
    input  ram_pkg::mem_word_u   merged,
    output ram_pkg::mem_req_s    req
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WRESP,
        ST_RRESP
    } state_e;

    state_e                            state_q;
    logic                              idle;
    logic                              wr_fire;
    logic                              rd_fire;
    logic                              strb_ok;
    ram_pkg::access_width_e            strb_width;
    logic                              req_valid_q;
    logic                              req_write_q;
    logic [ram_pkg::MAX_ADDR_W-1:0]    req_addr_q;
    ram_pkg::access_width_e            req_width_q;
    ram_pkg::mem_word_u                req_wdata_q;
    ram_pkg::mem_word_u                rdata_q;
    logic                              rd_held_q;
    logic [1:0]                        bresp_q;

    // ====================
    // Handshakes
    // ====================

    assign idle    = (state_q == ST_IDLE);
    assign awready = idle && (wvalid || !awvalid);     // AW never completes without W
    assign wready  = idle && (awvalid || !wvalid);
    assign arready = idle && !(awvalid && wvalid);     // Write wins a tie
    assign wr_fire = idle && awvalid && wvalid;
    assign rd_fire = arvalid && arready;

    always_comb begin
        strb_ok    = 1'b1;
        strb_width = ram_pkg::WIDTH_BYTE;
        case (wstrb)
            4'b0001: strb_width = ram_pkg::WIDTH_BYTE;
            4'b0011: strb_width = ram_pkg::WIDTH_HALF;
            4'b1111: strb_width = ram_pkg::WIDTH_WORD;
            default: strb_ok = 1'b0;
        endcase
    end

    // ====================
    // Control FSM
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= ST_IDLE;
            req_valid_q <= 1'b0;
            rd_held_q   <= 1'b0;
        end else begin
            req_valid_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (wr_fire) begin
                        if (strb_ok) begin
                            state_q     <= ST_ISSUE;
                            req_valid_q <= 1'b1;
                        end else begin
                            state_q <= ST_WRESP;  // Rejected store never reaches the banks
                        end
                    end else if (rd_fire) begin
                        state_q     <= ST_ISSUE;
                        req_valid_q <= 1'b1;
                    end
                end
                ST_ISSUE: begin
                    state_q <= req_write_q ? ST_WRESP : ST_RRESP;
                end
                ST_WRESP: begin
                    if (bready) begin
                        state_q <= ST_IDLE;
                    end
                end
                ST_RRESP: begin
                    rd_held_q <= 1'b1;
                    if (rready) begin
                        state_q   <= ST_IDLE;
                        rd_held_q <= 1'b0;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire || rd_fire) begin
            req_write_q                <= wr_fire;
            req_addr_q                 <= '0;
            req_addr_q[ADDR_W-1:0]     <= wr_fire ? awaddr : araddr;
            req_width_q                <= strb_width;
            req_wdata_q.word           <= wdata;
        end
        if (wr_fire) begin
            bresp_q <= strb_ok ? ram_pkg::RESP_OKAY : ram_pkg::RESP_SLVERR;
        end
        if (state_q == ST_RRESP && !rd_held_q) begin
            rdata_q <= merged;  // Freeze the word on the first response cycle
        end
    end

    always_comb begin
        req.valid = req_valid_q;
        req.write = req_write_q;
        req.addr  = req_addr_q;
        req.width = req_width_q;
        req.wdata = req_wdata_q;
    end

    assign bvalid = (state_q == ST_WRESP);
    assign rvalid = (state_q == ST_RRESP);
    assign bresp  = bresp_q;
    assign rresp  = ram_pkg::RESP_OKAY;
    assign rdata  = rd_held_q ? rdata_q.word : merged.word;

endmodule

//--- lane_router.sv
module lane_router #(
    parameter int ADDR_W = 16
) (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  ram_pkg::mem_req_s                             req,
    output ram_pkg::bank_cmd_s [ram_pkg::NUM_BANKS-1:0]   cmd,
    output logic [1:0]                                    lane_offset
);

    logic [1:0] lane_offset_q;

    // ====================
    // Per-bank commands
    // ====================

    always_comb begin
        logic [1:0]        idx;
        logic [ADDR_W-1:0] byte_addr;
        logic              in_width;

        for (int k = 0; k < ram_pkg::NUM_BANKS; k++) begin
            idx       = 2'(k) - req.addr[1:0];                     // Position of this bank's byte in the access
            byte_addr = req.addr[ADDR_W-1:0] + ADDR_W'(idx);   // Wraps at the top of memory

            case (req.width)
                ram_pkg::WIDTH_BYTE: in_width = (idx == 2'd0);
                ram_pkg::WIDTH_HALF: in_width = !idx[1];
                ram_pkg::WIDTH_WORD: in_width = 1'b1;
                default:             in_width = 1'b0;
            endcase

            cmd[k]                = '0;
            cmd[k].row[ADDR_W-3:0] = byte_addr[ADDR_W-1:2];
            cmd[k].we             = req.valid && req.write && in_width;
            cmd[k].re             = req.valid && !req.write;
            cmd[k].data           = req.wdata.bytes[idx];
        end
    end

    // The offset must line up with the bank output, one cycle after the request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_offset_q <= 2'd0;
        end else if (req.valid && !req.write) begin
            lane_offset_q <= req.addr[1:0];
        end
    end

    assign lane_offset = lane_offset_q;

endmodule

//--- sram_bank.sv
module sram_bank #(
    parameter int ADDR_W = 16
) (
    input  logic                clk,
    input  ram_pkg::bank_cmd_s  cmd,
    output logic [7:0]          rd_byte
);

    localparam int ROW_W = ADDR_W - 2;  // Four banks share the address space

    logic [7:0]       mem [2**ROW_W];
    logic [ROW_W-1:0] row;

    assign row = cmd.row[ROW_W-1:0];

    always_ff @(posedge clk) begin
        if (cmd.we) begin
            mem[row] <= cmd.data;
        end
        if (cmd.re) begin
            rd_byte <= mem[row];  // Held until the next read
        end
    end

endmodule

//--- load_merge.sv
module load_merge (
    input  logic [ram_pkg::NUM_BANKS-1:0][7:0]  bank_bytes,
    input  logic [1:0]                          lane_offset,
    output ram_pkg::mem_word_u                  merged
);

    // ====================
    // Byte rotation
    // ====================

    // Result byte j is the byte at address + j, which lives in bank (offset + j) mod 4
    always_comb begin
        logic [1:0] src;

        merged = '0;
        for (int j = 0; j < ram_pkg::NUM_BANKS; j++) begin
            src              = lane_offset + 2'(j);  // Two-bit sum wraps across the banks
            merged.bytes[j]  = bank_bytes[src];
        end
    end

endmodule

//--- data_ram_top.sv
module data_ram_top #(
    parameter int ADDR_W = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 awvalid,
    output logic                 awready,
    input  logic [ADDR_W-1:0]    awaddr,
    input  logic                 wvalid,
    output logic                 wready,
    input  logic [31:0]          wdata,
    input  logic [3:0]           wstrb,
    output logic                 bvalid,
    input  logic                 bready,
    output logic [1:0]           bresp,
    input  logic                 arvalid,
    output logic                 arready,
    input  logic [ADDR_W-1:0]    araddr,
    output logic                 rvalid,
    input  logic                 rready,
    output logic [31:0]          rdata,
    output logic [1:0]           rresp
);

    ram_pkg::mem_req_s                            req;
    ram_pkg::bank_cmd_s [ram_pkg::NUM_BANKS-1:0]  cmd;
    logic [ram_pkg::NUM_BANKS-1:0][7:0]           bank_bytes;
    logic [1:0]                                   lane_offset;
    ram_pkg::mem_word_u                           merged;

    // ====================
    // Front end
    // ====================

    axil_front #(
        .ADDR_W (ADDR_W)
    ) u_front (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .merged  (merged),
        .req     (req)
    );

    // ====================
    // Banked storage
    // ====================

    lane_router #(
        .ADDR_W (ADDR_W)
    ) u_router (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .cmd         (cmd),
        .lane_offset (lane_offset)
    );

    for (genvar k = 0; k < ram_pkg::NUM_BANKS; k++) begin : g_bank
        sram_bank #(
            .ADDR_W (ADDR_W)
        ) u_bank (
            .clk     (clk),
            .cmd     (cmd[k]),
            .rd_byte (bank_bytes[k])
        );
    end

    load_merge u_merge (
        .bank_bytes  (bank_bytes),
        .lane_offset (lane_offset),
        .merged      (merged)
    );

endmodule

//--- ram_checker.sv
module ram_checker #(
    parameter int ADDR_W = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               awvalid,
    input  logic               awready,
    input  logic [ADDR_W-1:0]  awaddr,
    input  logic               wvalid,
    input  logic               wready,
    input  logic [31:0]        wdata,
    input  logic [3:0]         wstrb,
    input  logic               bvalid,
    input  logic               bready,
    input  logic [1:0]         bresp,
    input  logic               arvalid,
    input  logic               arready,
    input  logic [ADDR_W-1:0]  araddr,
    input  logic               rvalid,
    input  logic               rready,
    input  logic [31:0]        rdata,
    input  logic [1:0]         rresp,
    output int                 err_count,
    output int                 test_count
);

    localparam int MEM_SIZE = 2**ADDR_W;

    logic [7:0]         model [MEM_SIZE];  // Bytes never written stay unknown
    int                 pending;           // 0 idle, 1 write, 2 read
    int                 cycles;
    int                 nbytes;
    int                 lat_exp;
    int                 errs_before;
    bit                 seen_valid;
    bit                 reset_checked;
    logic [ADDR_W-1:0]  cur_addr;
    logic [3:0]         cur_strb;
    logic [31:0]        exp_word;

    initial begin
        err_count     = 0;
        test_count    = 0;
        pending       = 0;
        reset_checked = 1'b0;
    end

    function automatic int strobe_bytes(input logic [3:0] strb);
        case (strb)
            4'b0001: return 1;
            4'b0011: return 2;
            4'b1111: return 4;
            default: return 0;  // Rejected with SLVERR
        endcase
    endfunction

    // Bytes the model has never seen are not compared
    function automatic bit word_matches(input logic [31:0] exp, input logic [31:0] act);
        bit ok;

        ok = 1'b1;
        for (int i = 0; i < 4; i++) begin
            if (!$isunknown(exp[8*i +: 8]) && act[8*i +: 8] !== exp[8*i +: 8]) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        err_count++;
        $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
    endtask

    task automatic report_problem(input string msg);
        err_count++;
        $display("Error at t=%0t: %s", $time, msg);
    endtask

    task automatic close_test(input string what);
        test_count++;
        $display("test %0d %s: %s", test_count, what,
                 (err_count == errs_before) ? "ok" : "error");
    endtask

    // ====================
    // Monitor
    // ====================

    always @(posedge clk) begin
        if (!rst_n) begin
            reset_checked = 1'b0;
            pending       = 0;
        end else begin
            if (!reset_checked) begin
                reset_checked = 1'b1;
                errs_before   = err_count;
                if (bvalid !== 1'b0)  report_value("bvalid", 32'd0, bvalid);
                if (rvalid !== 1'b0)  report_value("rvalid", 32'd0, rvalid);
                if (awready !== 1'b1) report_value("awready", 32'd1, awready);
                if (wready !== 1'b1)  report_value("wready", 32'd1, wready);
                if (arready !== 1'b1) report_value("arready", 32'd1, arready);
                close_test("reset state");
            end

            if (pending != 0) cycles++;
            if ((bvalid || rvalid) && (awready || wready || arready)) begin
                report_problem("an address channel is ready while a response is pending");
            end
            if (bvalid && pending != 1) report_problem("bvalid without an accepted write");
            if (rvalid && pending != 2) report_problem("rvalid without an accepted read");

            if (pending == 1 && bvalid) begin
                lat_exp = (nbytes != 0) ? 2 : 1;
                if (!seen_valid) begin
                    seen_valid = 1'b1;
                    if (cycles != lat_exp) report_value("bvalid latency", lat_exp, cycles);
                end
                if (bresp !== ((nbytes != 0) ? 2'b00 : 2'b10)) begin
                    report_value("bresp", (nbytes != 0) ? 32'h0 : 32'h2, bresp);
                end
                if (bready) begin
                    close_test($sformatf("write addr %h strb %b", cur_addr, cur_strb));
                    pending = 0;
                end
            end

            if (pending == 2 && rvalid) begin
                if (!seen_valid) begin
                    seen_valid = 1'b1;
                    if (cycles != 2) report_value("rvalid latency", 32'd2, cycles);
                end
                if (!word_matches(exp_word, rdata)) report_value("rdata", exp_word, rdata);
                if (rresp !== 2'b00) report_value("rresp", 32'h0, rresp);
                if (rready) begin
                    close_test($sformatf("read  addr %h", cur_addr));
                    pending = 0;
                end
            end

            if (awvalid && awready && wvalid && wready) begin
                pending     = 1;
                cycles      = 0;
                seen_valid  = 1'b0;
                cur_addr    = awaddr;
                cur_strb    = wstrb;
                nbytes      = strobe_bytes(wstrb);
                errs_before = err_count;
                for (int i = 0; i < nbytes; i++) begin
                    model[ADDR_W'(awaddr + i)] = wdata[8*i +: 8];  // Wraps at the top
                end
            end

            if (arvalid && arready) begin
                pending     = 2;
                cycles      = 0;
                seen_valid  = 1'b0;
                cur_addr    = araddr;
                errs_before = err_count;
                for (int i = 0; i < 4; i++) begin
                    exp_word[8*i +: 8] = model[ADDR_W'(araddr + i)];
                end
            end
        end
    end

endmodule

//--- tb_data_ram.sv
module tb_data_ram;

    localparam int ADDR_W  = 16;
    localparam int NUM_TXN = 240;
    localparam int PERIOD  = 40;

    logic               clk;
    logic               rst_n;
    logic               awvalid;
    logic               awready;
    logic [ADDR_W-1:0]  awaddr;
    logic               wvalid;
    logic               wready;
    logic [31:0]        wdata;
    logic [3:0]         wstrb;
    logic               bvalid;
    logic               bready;
    logic [1:0]         bresp;
    logic               arvalid;
    logic               arready;
    logic [ADDR_W-1:0]  araddr;
    logic               rvalid;
    logic               rready;
    logic [31:0]        rdata;
    logic [1:0]         rresp;
    int                 err_count;
    int                 test_count;
    int                 seed;
    int                 issued;
    logic [ADDR_W-1:0]  last_addr;

    data_ram_top #(.ADDR_W(ADDR_W)) dut (
        .clk (clk), .rst_n (rst_n),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp)
    );

    ram_checker #(.ADDR_W(ADDR_W)) chk (
        .clk (clk), .rst_n (rst_n),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp),
        .err_count (err_count), .test_count (test_count)
    );

    always #(PERIOD/2) clk = ~clk;

    // ====================
    // Stimulus helpers
    // ====================

    task automatic pick_addr(output logic [ADDR_W-1:0] a);
        int r;

        r = $random(seed);
        case (r & 3)
            0:       a = ADDR_W'(r[13:8]);              // Bottom 64 bytes
            1:       a = ~ADDR_W'(r[13:8]);             // Top 64 bytes where words wrap past the end
            2:       a = last_addr + ADDR_W'(r[9:8]);   // Overlaps the last store
            default: a = ADDR_W'(r[31:16]);
        endcase
    endtask

    task automatic pick_strb(output logic [3:0] s);
        int r;

        r = $random(seed);
        if ((r & 7) == 0) begin
            s = r[7:4];
            if (s == 4'b0001 || s == 4'b0011 || s == 4'b1111) s = s ^ 4'b0100;
        end else begin
            case (r[9:8])
                2'd0:    s = 4'b0001;
                2'd1:    s = 4'b0011;
                default: s = 4'b1111;
            endcase
        end
    endtask

    // Returns on the edge where the response is accepted
    task automatic wait_response(input bit is_read);
        int stall;
        bit done;

        stall = (($random(seed) & 3) == 0) ? (($random(seed) & 7) + 1) : 0;
        done  = 1'b0;
        if (is_read) rready <= (stall == 0);
        else         bready <= (stall == 0);
        while (!done) begin
            @(posedge clk);
            if (is_read ? (rvalid && rready) : (bvalid && bready)) begin
                done = 1'b1;
            end else if (is_read ? rvalid : bvalid) begin
                if (stall > 0) stall--;
                if (stall == 0) begin
                    if (is_read) rready <= 1'b1;
                    else         bready <= 1'b1;
                end
            end
        end
        rready <= 1'b0;
        bready <= 1'b0;
    endtask

    task automatic write_txn(input logic [ADDR_W-1:0] a, input logic [31:0] d,
                             input logic [3:0] s);
        awvalid <= 1'b1;
        awaddr  <= a;
        wvalid  <= 1'b1;
        wdata   <= d;
        wstrb   <= s;
        @(posedge clk);
        while (!(awready && wready)) @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        wait_response(1'b0);
        issued++;
    endtask

    task automatic read_txn(input logic [ADDR_W-1:0] a);
        arvalid <= 1'b1;
        araddr  <= a;
        @(posedge clk);
        while (!arready) @(posedge clk);
        arvalid <= 1'b0;
        wait_response(1'b1);
        issued++;
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        int                r;
        logic [ADDR_W-1:0] a;
        logic [31:0]       d;
        logic [31:0]       fill;
        logic [3:0]        s;

        seed      = 32'h7c9137ae;
        issued    = 0;
        last_addr = '0;
        clk       = 1'b0;
        rst_n     = 1'b0;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        bready    = 1'b0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);

        for (int n = 0; n < NUM_TXN; n++) begin
            r = $random(seed);
            pick_addr(a);
            if (r[2:0] < 3'd5) begin
                pick_strb(s);
                d = $random(seed);
                if (!(s == 4'b0001 || s == 4'b0011 || s == 4'b1111)) begin
                    fill = $random(seed);
                    write_txn(a, fill, 4'b1111);  // Known bytes under the rejected store
                    write_txn(a, d, s);
                    read_txn(a);  // Memory must be untouched by the rejected store
                end else begin
                    write_txn(a, d, s);
                end
                last_addr = a;
            end else begin
                read_txn(a);
            end
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        $display("Tests: %0d, errors: %0d", test_count, err_count);
        if (test_count != issued + 1) begin
            $display("Only %0d of %0d tests completed", test_count, issued + 1);
        end
        if (err_count == 0 && test_count == issued + 1) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (NUM_TXN * 20 + 100) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock periods",
                 NUM_TXN * 20 + 100);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- filelist.f
ram_pkg.sv
axil_front.sv
lane_router.sv
sram_bank.sv
load_merge.sv
data_ram_top.sv
ram_checker.sv
tb_data_ram.sv

//--- Bender.yml
package:
  name: data_ram

sources:
  - ram_pkg.sv
  - axil_front.sv
  - lane_router.sv
  - sram_bank.sv
  - load_merge.sv
  - data_ram_top.sv
  - target: test
    files:
      - ram_checker.sv
      - tb_data_ram.sv
